/* hw/bpu_consts.svh */
// sizing macros for the branch-predictor update path, included by every file that uses them
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// record slots in the resolve buffer, 2 or more
`define BPU_BUF_DEPTH 4

// prediction table index, taken from the low pc bits
`define BPU_IDX_W 6

// word-address pc
`define BPU_PC_W 30

`endif

/* hw/bpu_pkg.sv */
// shared types for the branch-predictor update path: branch kind, resolved record, table entry
`default_nettype none

`include "bpu_consts.svh"

package bpu_pkg;

    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_cond = 3'd1,
        br_jump = 3'd2,
        br_call = 3'd3,
        br_ret  = 3'd4,
        br_ind  = 3'd5
    } br_kind_e;

    // one branch as resolved by execute, 98 bits
    // actual outcome in the upper half, predicted outcome below
    typedef struct packed {
        logic [`BPU_PC_W-1:0] pc_ex;
        logic [`BPU_PC_W-1:0] npc_ex;
        br_kind_e             kind_ex;
        logic                 taken_ex;
        logic [`BPU_PC_W-1:0] npc_pdc;
        br_kind_e             kind_pdc;
        logic                 taken_pdc;
    } br_rec_t;

    // prediction table entry
    typedef struct packed {
        logic                           valid;
        logic [`BPU_PC_W-`BPU_IDX_W-1:0] tag;
        br_kind_e                       kind;
        logic                           taken;
        logic [`BPU_PC_W-1:0]           target;
    } tbl_entry_t;

endpackage

`default_nettype wire

/* hw/tbl_port_if.sv */
// one requester's access to the prediction table, shared by the lookup unit and the updater
`timescale 1ns/1ns
`default_nettype none

`include "bpu_consts.svh"

interface tbl_port_if;

    logic                   req;
    logic                   we;
    logic [`BPU_IDX_W-1:0]  idx;
    bpu_pkg::tbl_entry_t    wentry;
    // same-cycle grant and read data one cycle later
    logic                   gnt;
    bpu_pkg::tbl_entry_t    rentry;

    modport requester (
        output req,
        output we,
        output idx,
        output wentry,
        input  gnt,
        input  rentry
    );

    modport tbl (
        input  req,
        input  we,
        input  idx,
        input  wentry,
        output gnt,
        output rentry
    );

endinterface

`default_nettype wire

/* hw/resolve_buffer.sv */
// in-order buffer of resolved branches: takes one or two records per cycle, hands out the oldest
`timescale 1ns/1ns
`default_nettype none

`include "bpu_consts.svh"

module resolve_buffer (
    input  wire                                     clk,
    input  wire                                     rstn,
    input  wire                                     push,
    input  wire                                     two,
    input  bpu_pkg::br_rec_t                        rec_0,
    input  bpu_pkg::br_rec_t                        rec_1,
    input  wire                                     pop,
    output bpu_pkg::br_rec_t                        head,
    output logic                                    head_valid,
    output logic                                    stall,
    output logic [$clog2(`BPU_BUF_DEPTH + 1)-1:0]   count
);

    localparam int DEPTH = `BPU_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    bpu_pkg::br_rec_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_1;
    logic [CNT_W-1:0] push_n;

    // wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_ptr_1 = ptr_inc(wr_ptr);

    always_comb begin
        push_n = '0;
        if (push) begin
            push_n = two ? CNT_W'(2) : CNT_W'(1);
        end
    end

    // rec_0 is older, so it takes the first free slot
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rec_0;
            if (two) begin
                mem[wr_ptr_1] <= rec_1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= two ? ptr_inc(wr_ptr_1) : wr_ptr_1;
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + push_n - CNT_W'(pop);
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // hold off the producer unless a dual push still fits
    assign stall = (count > CNT_W'(DEPTH - 2));

endmodule

`default_nettype wire

/* hw/bpu_updater.sv */
// drains resolved branches and writes the prediction table on a misprediction
`timescale 1ns/1ns
`default_nettype none

`include "bpu_consts.svh"

module bpu_updater (
    input  wire                     clk,
    input  wire                     rstn,
    input  bpu_pkg::br_rec_t        head,
    input  wire                     head_valid,
    output logic                    pop,
    output logic                    busy,
    tbl_port_if.requester           port
);

    logic                   mispredict;
    logic                   writing;
    logic [`BPU_IDX_W-1:0]  wr_idx_q;
    bpu_pkg::tbl_entry_t    wr_entry_q;

    // next pc only matters when the branch was really taken
    assign mispredict = (head.taken_pdc != head.taken_ex) ||
                        (head.taken_ex && (head.npc_pdc != head.npc_ex));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            writing <= 1'b0;
        end else if (writing) begin
            writing <= !port.gnt;
        end else begin
            writing <= head_valid && mispredict;
        end
    end

    // write data is captured once, the head stays put until the grant
    always_ff @(posedge clk) begin
        if (!writing && head_valid && mispredict) begin
            wr_idx_q          <= head.pc_ex[`BPU_IDX_W-1:0];
            wr_entry_q.valid  <= 1'b1;
            wr_entry_q.tag    <= head.pc_ex[`BPU_PC_W-1:`BPU_IDX_W];
            wr_entry_q.kind   <= head.kind_ex;
            wr_entry_q.taken  <= head.taken_ex;
            wr_entry_q.target <= head.npc_ex;
        end
    end

    assign port.req    = writing;
    assign port.we     = 1'b1;
    assign port.idx    = wr_idx_q;
    assign port.wentry = wr_entry_q;

    assign pop  = head_valid && (writing ? port.gnt : !mispredict);
    assign busy = writing;

endmodule

`default_nettype wire

/* hw/bpu_lookup.sv */
// fetch-side lookup: reads the table for a fetch pc and predicts its next pc a cycle later
`timescale 1ns/1ns
`default_nettype none

`include "bpu_consts.svh"

module bpu_lookup (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         lookup_req,
    input  wire [`BPU_PC_W-1:0]         lookup_pc,
    output logic                        pred_valid,
    output logic                        pred_taken,
    output bpu_pkg::br_kind_e           pred_kind,
    output logic [`BPU_PC_W-1:0]        pred_npc,
    tbl_port_if.requester               port
);

    logic [`BPU_PC_W-1:0]   pc_q;
    logic [`BPU_PC_W-1:0]   pc_next;
    logic                   hit;

    // lookup has priority, so the read is granted in the same cycle
    assign port.req    = lookup_req;
    assign port.we     = 1'b0;
    assign port.idx    = lookup_pc[`BPU_IDX_W-1:0];
    assign port.wentry = '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= lookup_req;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req) begin
            pc_q <= lookup_pc;
        end
    end

    assign pc_next = pc_q + 1'b1;
    assign hit     = port.rentry.valid &&
                     (port.rentry.tag == pc_q[`BPU_PC_W-1:`BPU_IDX_W]);

    always_comb begin
        pred_taken = 1'b0;
        pred_kind  = bpu_pkg::br_none;
        pred_npc   = pc_next;
        if (hit) begin
            pred_taken = port.rentry.taken;
            pred_kind  = port.rentry.kind;
            if (port.rentry.taken) begin
                pred_npc = port.rentry.target;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/pred_table.sv */
// single-port prediction table shared by lookup and update where the lookup port wins
`timescale 1ns/1ns
`default_nettype none

`include "bpu_consts.svh"

module pred_table (
    input  wire             clk,
    input  wire             rstn,
    tbl_port_if.tbl         lk,
    tbl_port_if.tbl         up
);

    localparam int N = 1 << `BPU_IDX_W;

    bpu_pkg::tbl_entry_t    mem [N];
    logic [N-1:0]           vld;

    logic                   acc;
    logic                   acc_we;
    logic [`BPU_IDX_W-1:0]  acc_idx;
    bpu_pkg::tbl_entry_t    acc_wentry;

    bpu_pkg::tbl_entry_t    rd_q;
    logic                   rd_vld_q;
    bpu_pkg::tbl_entry_t    rd_entry;

    // fixed priority with one access per cycle
    assign lk.gnt = lk.req;
    assign up.gnt = up.req && !lk.req;

    assign acc        = lk.req || up.req;
    assign acc_we     = lk.req ? lk.we : up.we;
    assign acc_idx    = lk.req ? lk.idx : up.idx;
    assign acc_wentry = lk.req ? lk.wentry : up.wentry;

    always_ff @(posedge clk) begin
        if (acc && acc_we) begin
            mem[acc_idx] <= acc_wentry;
        end
        if (acc && !acc_we) begin
            rd_q <= mem[acc_idx];
        end
    end

    // per-entry valid bits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld      <= '0;
            rd_vld_q <= 1'b0;
        end else if (acc) begin
            if (acc_we) begin
                vld[acc_idx] <= acc_wentry.valid;
            end else begin
                rd_vld_q <= vld[acc_idx];
            end
        end
    end

    always_comb begin
        rd_entry       = rd_q;
        rd_entry.valid = rd_vld_q;
    end

    assign lk.rentry = rd_entry;
    assign up.rentry = rd_entry;

endmodule

`default_nettype wire

/* hw/bpu_top.sv */
// top of the branch-predictor update path with resolve buffer, updater, lookup and shared table
`timescale 1ns/1ns
`default_nettype none

`include "bpu_consts.svh"

module bpu_top (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         push,
    input  wire                         two,
    input  bpu_pkg::br_rec_t            rec_0,
    input  bpu_pkg::br_rec_t            rec_1,
    input  wire                         lookup_req,
    input  wire [`BPU_PC_W-1:0]         lookup_pc,
    output logic                        stall,
    output logic                        pending,
    output logic                        pred_valid,
    output logic                        pred_taken,
    output bpu_pkg::br_kind_e           pred_kind,
    output logic [`BPU_PC_W-1:0]        pred_npc
);

    bpu_pkg::br_rec_t   buf_head;
    logic               buf_head_valid;
    logic               buf_pop;
    logic               up_busy;

    tbl_port_if lk_port ();
    tbl_port_if up_port ();

    resolve_buffer u_buf (
        .clk        (clk),
        .rstn       (rstn),
        .push       (push),
        .two        (two),
        .rec_0      (rec_0),
        .rec_1      (rec_1),
        .pop        (buf_pop),
        .head       (buf_head),
        .head_valid (buf_head_valid),
        .stall      (stall),
        .count      ()
    );

    bpu_updater u_updater (
        .clk        (clk),
        .rstn       (rstn),
        .head       (buf_head),
        .head_valid (buf_head_valid),
        .pop        (buf_pop),
        .busy       (up_busy),
        .port       (up_port.requester)
    );

    bpu_lookup u_lookup (
        .clk        (clk),
        .rstn       (rstn),
        .lookup_req (lookup_req),
        .lookup_pc  (lookup_pc),
        .pred_valid (pred_valid),
        .pred_taken (pred_taken),
        .pred_kind  (pred_kind),
        .pred_npc   (pred_npc),
        .port       (lk_port.requester)
    );

    pred_table u_table (
        .clk        (clk),
        .rstn       (rstn),
        .lk         (lk_port.tbl),
        .up         (up_port.tbl)
    );

    // records still on their way into the table
    assign pending = buf_head_valid || up_busy;

endmodule

`default_nettype wire

/* test/bpu_chk.sv */
// concurrent checks on the resolve buffer and table arbiter that are bound into bpu_top
`timescale 1ns/1ns
`default_nettype none

module bpu_chk (
    input wire clk,
    input wire rstn,
    input wire push,
    input wire stall,
    input wire pop,
    input wire head_valid,
    input wire lk_gnt,
    input wire up_gnt,
    input wire lookup_req,
    input wire pred_valid
);

    int fails = 0;

    // producer must respect stall
    a_push_stall: assert property (@(posedge clk) disable iff (!rstn) push |-> !stall)
        else begin
            $error("push while stall is high");
            fails++;
        end

    a_pop_valid: assert property (@(posedge clk) disable iff (!rstn) pop |-> head_valid)
        else begin
            $error("pop from an empty buffer");
            fails++;
        end

    // lookup wins and only one access happens per cycle
    a_one_gnt: assert property (@(posedge clk) disable iff (!rstn) !(lk_gnt && up_gnt))
        else begin
            $error("both table ports granted");
            fails++;
        end

    a_pred_after: assert property (@(posedge clk) disable iff (!rstn) lookup_req |=> pred_valid)
        else begin
            $error("pred_valid missing after lookup_req");
            fails++;
        end

    a_pred_only: assert property (@(posedge clk) disable iff (!rstn) !lookup_req |=> !pred_valid)
        else begin
            $error("pred_valid without lookup_req");
            fails++;
        end

endmodule

bind bpu_top bpu_chk u_chk (
    .clk        (clk),
    .rstn       (rstn),
    .push       (push),
    .stall      (stall),
    .pop        (buf_pop),
    .head_valid (buf_head_valid),
    .lk_gnt     (lk_port.gnt),
    .up_gnt     (up_port.gnt),
    .lookup_req (lookup_req),
    .pred_valid (pred_valid)
);

`default_nettype wire

/* test/bpu_tb.sv */
// testbench for bpu_top that checks directed and random branch updates against a model table
`timescale 1ns/1ns
`default_nettype none

`include "bpu_consts.svh"

module bpu_tb;

    localparam int PCW = `BPU_PC_W;
    localparam int IW  = `BPU_IDX_W;

    typedef struct packed {
        logic               taken;
        bpu_pkg::br_kind_e  kind;
        logic [PCW-1:0]     npc;
    } pred_t;

    logic               clk;
    logic               rstn;
    logic               push;
    logic               two;
    bpu_pkg::br_rec_t   rec_0;
    bpu_pkg::br_rec_t   rec_1;
    logic               lookup_req;
    logic [PCW-1:0]     lookup_pc;
    logic               stall;
    logic               pending;
    logic               pred_valid;
    logic               pred_taken;
    bpu_pkg::br_kind_e  pred_kind;
    logic [PCW-1:0]     pred_npc;

    bpu_pkg::tbl_entry_t    model [1 << IW];
    bpu_pkg::br_rec_t       rec_q [$];
    pred_t                  exp_q [$];
    logic [31:0]            rng = 32'd69;

    bpu_top u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .push       (push),
        .two        (two),
        .rec_0      (rec_0),
        .rec_1      (rec_1),
        .lookup_req (lookup_req),
        .lookup_pc  (lookup_pc),
        .stall      (stall),
        .pending    (pending),
        .pred_valid (pred_valid),
        .pred_taken (pred_taken),
        .pred_kind  (pred_kind),
        .pred_npc   (pred_npc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // three tags over eight indexes to force overwrites
    function automatic logic [PCW-1:0] rand_pc();
        return PCW'(((next_rand() % 3) << IW) + (next_rand() % 8));
    endfunction

    function automatic bpu_pkg::br_rec_t make_rec(input logic [PCW-1:0] pc, input logic tk,
            input bpu_pkg::br_kind_e kind, input logic [PCW-1:0] npc,
            input logic tk_p, input logic [PCW-1:0] npc_p);
        return '{pc, npc, kind, tk, npc_p, kind, tk_p};
    endfunction

    // about half of these mispredict
    function automatic bpu_pkg::br_rec_t rand_rec();
        bpu_pkg::br_rec_t r;
        r = make_rec(rand_pc(), 1'(next_rand()), bpu_pkg::br_kind_e'(next_rand() % 6),
                     PCW'(next_rand()), 1'b0, '0);
        r.taken_pdc = r.taken_ex;
        r.npc_pdc   = r.npc_ex;
        case (next_rand() % 4)
            0: r.taken_pdc = !r.taken_ex;
            1: r.npc_pdc = PCW'(next_rand());
            default: ;
        endcase
        return r;
    endfunction

    function automatic void apply_rec(input bpu_pkg::br_rec_t r);
        if (r.taken_pdc != r.taken_ex || (r.taken_ex && r.npc_pdc != r.npc_ex))
            model[r.pc_ex[IW-1:0]] = '{1'b1, r.pc_ex[PCW-1:IW], r.kind_ex, r.taken_ex, r.npc_ex};
    endfunction

    function automatic pred_t ref_pred(input logic [PCW-1:0] pc);
        bpu_pkg::tbl_entry_t e;
        pred_t p;
        e = model[pc[IW-1:0]];
        p = '{1'b0, bpu_pkg::br_none, pc + 1'b1};
        if (e.valid && e.tag == pc[PCW-1:IW]) begin
            p.taken = e.taken;
            p.kind  = e.kind;
            if (e.taken)
                p.npc = e.target;
        end
        return p;
    endfunction

    task automatic abort(input string what);
        $display("%s at %0t", what, $time);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [PCW-1:0] got,
            input logic [PCW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #10;
        push       = 1'b0;
        two        = 1'b0;
        lookup_req = 1'b0;
    endtask

    // once pending is low every pushed record is in the table
    task automatic wait_idle();
        int n;
        n = 0;
        while (pending) begin
            if (n == 200)
                abort("pending stayed high");
            tick();
            n++;
        end
        while (rec_q.size() > 0)
            apply_rec(rec_q.pop_front());
    endtask

    task automatic push_recs(input logic dual, input bpu_pkg::br_rec_t r0,
            input bpu_pkg::br_rec_t r1);
        int n;
        n = 0;
        while (stall) begin
            if (n == 200)
                abort("stall stayed high");
            tick();
            n++;
        end
        push  = 1'b1;
        two   = dual;
        rec_0 = r0;
        rec_1 = r1;
        rec_q.push_back(r0);
        if (dual)
            rec_q.push_back(r1);
    endtask

    task automatic lookup(input logic [PCW-1:0] pc);
        lookup_req = 1'b1;
        lookup_pc  = pc;
        exp_q.push_back(ref_pred(pc));
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() > 0) begin
            if (n == 50)
                abort("pred_valid did not arrive");
            tick();
            n++;
        end
    endtask

    task automatic sweep();
        for (int i = 0; i < 24; i++) begin
            lookup(PCW'(((i / 8) << IW) + (i % 8)));
            tick();
        end
        drain();
    endtask

    // compare every prediction pulse mid-cycle
    initial begin
        pred_t e;
        forever begin
            @(negedge clk);
            if (u_dut.u_chk.fails != 0)
                abort("an assertion in the bound checker failed");
            if (pred_valid) begin
                if (exp_q.size() == 0)
                    abort("pred_valid without a lookup");
                e = exp_q.pop_front();
                check("pred_taken", PCW'(pred_taken), PCW'(e.taken));
                check("pred_kind", PCW'(pred_kind), PCW'(e.kind));
                check("pred_npc", pred_npc, e.npc);
            end
        end
    end

    initial begin
        logic saw_stall;
        bpu_pkg::br_rec_t r;
        for (int i = 0; i < (1 << IW); i++)
            model[i] = '0;
        rstn       = 1'b0;
        push       = 1'b0;
        two        = 1'b0;
        rec_0      = '0;
        rec_1      = '0;
        lookup_req = 1'b0;
        lookup_pc  = '0;
        repeat (16) @(posedge clk);
        #10;
        rstn = 1'b1;
        check("stall", PCW'(stall), '0);
        check("pending", PCW'(pending), '0);
        check("pred_valid", PCW'(pred_valid), '0);

        // empty table misses everywhere
        for (int i = 0; i < 8; i++) begin
            tick();
            lookup(rand_pc());
        end
        drain();

        // single mispredict
        push_recs(1'b0, make_rec(30'h10A, 1'b1, bpu_pkg::br_jump, 30'h3000, 1'b0, '0), '0);
        tick();
        wait_idle();
        lookup(30'h10A);
        tick();
        drain();

        // two mispredicts on one index where the younger one wins
        push_recs(1'b1, make_rec(30'h0C5, 1'b1, bpu_pkg::br_call, 30'h7000, 1'b0, '0),
                  make_rec(30'h0C5, 1'b0, bpu_pkg::br_cond, 30'h0C6, 1'b1, 30'h7000));
        tick();
        wait_idle();
        lookup(30'h0C5);
        tick();
        drain();

        // correctly predicted records leave the table alone
        push_recs(1'b1, make_rec(30'h10A, 1'b1, bpu_pkg::br_ind, 30'h5555, 1'b1, 30'h5555),
                  make_rec(30'h0C5, 1'b0, bpu_pkg::br_ret, 30'h1, 1'b0, 30'h2));
        tick();
        wait_idle();
        lookup(30'h10A);
        tick();
        lookup(30'h0C5);
        tick();
        drain();

        // lookups every cycle keep the updater out until the buffer fills
        saw_stall = 1'b0;
        for (int i = 0; i < 24; i++) begin
            tick();
            lookup(rand_pc());
            if (stall) begin
                saw_stall = 1'b1;
            end else begin
                r = rand_rec();
                r.taken_pdc = !r.taken_ex;
                push_recs(1'b1, r, rand_rec());
            end
        end
        tick();
        if (!saw_stall)
            abort("stall never rose under constant lookups");
        wait_idle();
        sweep();

        // random mix with lookups only while nothing is pending
        for (int i = 0; i < 300; i++) begin
            tick();
            case (next_rand() % 4)
                0: if (!stall) push_recs(1'b0, rand_rec(), '0);
                1: if (!stall) push_recs(1'b1, rand_rec(), rand_rec());
                default: begin
                    if (!pending) begin
                        wait_idle();
                        lookup(rand_pc());
                    end
                end
            endcase
        end
        tick();
        wait_idle();
        sweep();

        if (u_dut.u_chk.fails == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort("an assertion in the bound checker failed");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/bpu_pkg.sv
hw/tbl_port_if.sv
hw/resolve_buffer.sv
hw/bpu_updater.sv
hw/bpu_lookup.sv
hw/pred_table.sv
hw/bpu_top.sv
test/bpu_chk.sv
test/bpu_tb.sv

/* Bender.yml */
package:
  name: bpu_update

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bpu_pkg.sv
      - hw/tbl_port_if.sv
      - hw/resolve_buffer.sv
      - hw/bpu_updater.sv
      - hw/bpu_lookup.sv
      - hw/pred_table.sv
      - hw/bpu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/bpu_chk.sv
      - test/bpu_tb.sv
